// ==== project.f ====
hdl/eth_repeater_pkg.sv
hdl/xgmii_lane_align.sv
hdl/link_supervisor.sv
hdl/eth_repeater_top.sv
tests/eth_repeater_checker.sv
tests/tb_eth_repeater.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the repeater testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
STATUS=0

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module tb_eth_repeater -o tb_eth_repeater

./obj_dir/tb_eth_repeater > "$LOG" 2>&1 || STATUS=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

if [ "$STATUS" -ne 0 ]; then
  echo "simulation exited with status $STATUS"
  exit 1
fi

exit 0

// ==== tests/tb_eth_repeater.sv ====
`timescale 1ns/1ps

module tb_eth_repeater;

  localparam int GEN_LATENCY = 64;
  localparam int HB_W        = 12;
  localparam int CW          = eth_repeater_pkg::XGMII_CTRL_W;
  localparam int DW          = eth_repeater_pkg::DEBUG_W;
  localparam int HALF        = eth_repeater_pkg::XGMII_LANES / 2;
  localparam int RST_CYCLES  = 5;
  localparam int RUN_CYCLES  = 300;
  // two phases, each a reset then traffic
  localparam int TOTAL_CYCLES   = 2 * (RST_CYCLES + RUN_CYCLES);
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 2 * GEN_LATENCY;
  localparam int unsigned SEED  = 32'h4dae;
  localparam logic [7:0] TERM_CHAR = 8'hfd;
  localparam logic [7:0] PREAMBLE  = 8'h55;

  logic clk156 = 1'b0;
  logic eth_rst;
  eth_repeater_pkg::xgmii_data_u rx_d [2];
  logic [CW-1:0]                 rx_c [2];
  eth_repeater_pkg::xgmii_data_u tx0_d;
  eth_repeater_pkg::xgmii_data_u tx1_d;
  logic [CW-1:0]                 tx0_c;
  logic [CW-1:0]                 tx1_c;
  logic                          link_up;
  logic [DW-1:0]                 debug;

  // reference model state
  eth_repeater_pkg::xgmii_data_u m_prev_d [2];
  logic [CW-1:0]                 m_prev_c [2];
  logic                          m_shift  [2];
  eth_repeater_pkg::xgmii_data_u m_algn_d [2];
  logic [CW-1:0]                 m_algn_c [2];
  eth_repeater_pkg::xgmii_data_u m_tx_d   [2];
  logic [CW-1:0]                 m_tx_c   [2];
  logic                          m_link;
  int                            m_hold;
  logic [HB_W-1:0]               m_hb;

  // frame generator, -1 between frames, 0 means closing word next
  int frame_left [2];
  // mode switches seen per port
  int to_shift  [2];
  int to_direct [2];
  int cycle_cnt = 0;

  always #4 clk156 = ~clk156;

  eth_repeater_top #(
    .GEN_LATENCY (GEN_LATENCY),
    .HEARTBEAT_W (HB_W)
  ) u_dut (
    .clk156    (clk156),
    .eth_rst   (eth_rst),
    .rx0_d_i   (rx_d[0]),
    .rx0_c_i   (rx_c[0]),
    .rx1_d_i   (rx_d[1]),
    .rx1_c_i   (rx_c[1]),
    .tx0_d_o   (tx0_d),
    .tx0_c_o   (tx0_c),
    .tx1_d_o   (tx1_d),
    .tx1_c_o   (tx1_c),
    .link_up_o (link_up),
    .debug_o   (debug)
  );

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic cmp_word(input string what, input eth_repeater_pkg::xgmii_data_u got,
                          input eth_repeater_pkg::xgmii_data_u exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic cmp_ctrl(input string what, input logic [CW-1:0] got,
                          input logic [CW-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic cmp_link(input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0t: link_up is %b, expected %b", $time, got, exp));
    end
  endtask

  task automatic cmp_debug(input logic [DW-1:0] got, input logic [DW-1:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED at %0t: debug is %h, expected %h", $time, got, exp));
    end
  endtask

  // one clock edge of the model, inputs as seen at the edge
  task automatic model_edge();
    eth_repeater_pkg::xgmii_data_u nxt_d;
    logic [CW-1:0]                 nxt_c;
    logic                          st0;
    logic                          st4;
    logic                          mode;
    for (int p = 0; p < 2; p++) begin
      if (eth_rst) begin
        m_prev_d[p] = eth_repeater_pkg::IDLE_DATA;
        m_prev_c[p] = '1;
        m_shift[p]  = 1'b0;
        m_algn_d[p] = eth_repeater_pkg::IDLE_DATA;
        m_algn_c[p] = '1;
        m_tx_d[p]   = eth_repeater_pkg::IDLE_DATA;
        m_tx_c[p]   = '1;
      end else begin
        // crossed, uses aligned word and link state from before this edge
        m_tx_d[p] = m_link ? m_algn_d[1-p] : eth_repeater_pkg::IDLE_DATA;
        m_tx_c[p] = m_link ? m_algn_c[1-p] : '1;
      end
    end
    if (eth_rst) begin
      m_link = 1'b0;
      m_hold = 0;
      m_hb   = '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        // start found in the previous word decides the mode
        st0  = m_prev_c[p][0] && (m_prev_d[p].lane[0] == eth_repeater_pkg::START_CHAR);
        st4  = m_prev_c[p][HALF] &&
               (m_prev_d[p].lane[HALF] == eth_repeater_pkg::START_CHAR);
        mode = st4 ? 1'b1 : (st0 ? 1'b0 : m_shift[p]);
        if (mode && !m_shift[p]) begin
          to_shift[p] = to_shift[p] + 1;
        end
        if (!mode && m_shift[p]) begin
          to_direct[p] = to_direct[p] + 1;
        end
        if (mode) begin
          // lanes 4..7 of old word down, lanes 0..3 of new word up
          for (int l = 0; l < HALF; l++) begin
            nxt_d.lane[l]        = m_prev_d[p].lane[l + HALF];
            nxt_d.lane[l + HALF] = rx_d[p].lane[l];
            nxt_c[l]             = m_prev_c[p][l + HALF];
            nxt_c[l + HALF]      = rx_c[p][l];
          end
        end else begin
          nxt_d = m_prev_d[p];
          nxt_c = m_prev_c[p];
        end
        m_algn_d[p] = nxt_d;
        m_algn_c[p] = nxt_c;
        m_prev_d[p] = rx_d[p];
        m_prev_c[p] = rx_c[p];
        m_shift[p]  = mode;
      end
      // hold ends on the GEN_LATENCY-th edge after release
      if (!m_link) begin
        m_hold = m_hold + 1;
        if (m_hold == GEN_LATENCY) begin
          m_link = 1'b1;
        end
      end
      m_hb = m_hb + 1'b1;
    end
  endtask

  // next random xgmii word for one port
  task automatic gen_word(input int p);
    int unsigned pick;
    rx_d[p] = eth_repeater_pkg::IDLE_DATA;
    rx_c[p] = '1;
    if (frame_left[p] > 0) begin
      rx_d[p] = {$urandom, $urandom};
      rx_c[p] = '0;
      frame_left[p] = frame_left[p] - 1;
    end else if (frame_left[p] == 0) begin
      // terminate in lane 0, or just idle
      if ($urandom_range(1, 0) == 0) begin
        rx_d[p].lane[0] = TERM_CHAR;
      end
      frame_left[p] = -1;
    end else begin
      pick = $urandom_range(4, 0);
      if (pick == 3) begin
        // start in lane 0, preamble after it
        rx_d[p].lane[0] = eth_repeater_pkg::START_CHAR;
        for (int l = 1; l < eth_repeater_pkg::XGMII_LANES; l++) begin
          rx_d[p].lane[l] = PREAMBLE;
        end
        rx_c[p] = 8'h01;
        frame_left[p] = $urandom_range(6, 1);
      end else if (pick == 4) begin
        // idles in lanes 0..3, start in lane 4
        rx_d[p].lane[HALF] = eth_repeater_pkg::START_CHAR;
        for (int l = HALF + 1; l < eth_repeater_pkg::XGMII_LANES; l++) begin
          rx_d[p].lane[l] = PREAMBLE;
        end
        rx_c[p] = 8'h1f;
        frame_left[p] = $urandom_range(6, 1);
      end
    end
  endtask

  // edge, model, check outputs, then drive next inputs
  task automatic step();
    @(posedge clk156);
    model_edge();
    #1;
    cmp_word("tx0 data", tx0_d, m_tx_d[0]);
    cmp_ctrl("tx0 ctrl", tx0_c, m_tx_c[0]);
    cmp_word("tx1 data", tx1_d, m_tx_d[1]);
    cmp_ctrl("tx1 ctrl", tx1_c, m_tx_c[1]);
    cmp_link(link_up, m_link);
    cmp_debug(debug, m_hb[HB_W-1 -: DW]);
    gen_word(0);
    gen_word(1);
  endtask

  task automatic run_phase();
    eth_rst = 1'b1;
    repeat (RST_CYCLES) step();
    eth_rst = 1'b0;
    repeat (RUN_CYCLES) step();
  endtask

  initial begin
    void'($urandom(SEED));
    eth_rst = 1'b1;
    for (int p = 0; p < 2; p++) begin
      rx_d[p]       = eth_repeater_pkg::IDLE_DATA;
      rx_c[p]       = '1;
      frame_left[p] = -1;
      to_shift[p]   = 0;
      to_direct[p]  = 0;
    end
    // second phase is the mid-run reset
    run_phase();
    run_phase();
    if (to_shift[0] > 0 && to_shift[1] > 0 && to_direct[0] > 0 && to_direct[1] > 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_run("traffic never switched both ports into and out of shifted mode");
    end
  end

  // cycle limit
  always @(posedge clk156) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      stop_run($sformatf("run timed out after %0d clock cycles", cycle_cnt));
    end
  end

endmodule

// ==== tests/eth_repeater_checker.sv ====
`timescale 1ns/1ps

module eth_repeater_checker (
  input logic                                      clk156,
  input logic                                      eth_rst,
  input eth_repeater_pkg::xgmii_data_u             tx0_d_i,
  input logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] tx0_c_i,
  input eth_repeater_pkg::xgmii_data_u             tx1_d_i,
  input logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] tx1_c_i,
  input logic                                      link_up_i,
  input logic [eth_repeater_pkg::DEBUG_W-1:0]      debug_i
);

  // link down means idle on both tx ports
  a_idle_while_down: assert property (
    @(posedge clk156) disable iff (eth_rst)
    !link_up_i |-> (tx0_d_i == eth_repeater_pkg::IDLE_DATA) && (tx0_c_i == '1) &&
                   (tx1_d_i == eth_repeater_pkg::IDLE_DATA) && (tx1_c_i == '1)
  ) else $error("tx port not idle while link is down");

  // link_up only drops through reset
  a_link_sticky: assert property (
    @(posedge clk156)
    (link_up_i && !eth_rst) |=> link_up_i
  ) else $error("link_up fell without reset");

  // heartbeat cleared by reset
  a_debug_cleared: assert property (
    @(posedge clk156)
    eth_rst |=> (debug_i == '0)
  ) else $error("debug not zero after reset");

endmodule

bind link_supervisor eth_repeater_checker u_checker (
  .clk156    (clk156),
  .eth_rst   (eth_rst),
  .tx0_d_i   (tx0_d_o),
  .tx0_c_i   (tx0_c_o),
  .tx1_d_i   (tx1_d_o),
  .tx1_c_i   (tx1_c_o),
  .link_up_i (link_up_o),
  .debug_i   (debug_o)
);

// ==== hdl/eth_repeater_top.sv ====
`timescale 1ns/1ps

module eth_repeater_top #(
  parameter int GEN_LATENCY = 1024,
  parameter int HEARTBEAT_W = 32
) (
  input  logic                                      clk156,
  input  logic                                      eth_rst,
  input  eth_repeater_pkg::xgmii_data_u             rx0_d_i,
  input  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] rx0_c_i,
  input  eth_repeater_pkg::xgmii_data_u             rx1_d_i,
  input  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] rx1_c_i,
  output eth_repeater_pkg::xgmii_data_u             tx0_d_o,
  output logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] tx0_c_o,
  output eth_repeater_pkg::xgmii_data_u             tx1_d_o,
  output logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] tx1_c_o,
  output logic                                      link_up_o,
  output logic [eth_repeater_pkg::DEBUG_W-1:0]      debug_o
);

  // aligned receive words, two cycles after rx
  eth_repeater_pkg::xgmii_data_u             algn0_d;
  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] algn0_c;
  eth_repeater_pkg::xgmii_data_u             algn1_d;
  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] algn1_c;

  // port 0 receive
  xgmii_lane_align u_align0 (
    .clk156   (clk156),
    .eth_rst  (eth_rst),
    .rx_d_i   (rx0_d_i),
    .rx_c_i   (rx0_c_i),
    .algn_d_o (algn0_d),
    .algn_c_o (algn0_c)
  );

  // port 1 receive
  xgmii_lane_align u_align1 (
    .clk156   (clk156),
    .eth_rst  (eth_rst),
    .rx_d_i   (rx1_d_i),
    .rx_c_i   (rx1_c_i),
    .algn_d_o (algn1_d),
    .algn_c_o (algn1_c)
  );

  // crossing, startup hold and heartbeat, one more cycle
  link_supervisor #(
    .GEN_LATENCY (GEN_LATENCY),
    .HEARTBEAT_W (HEARTBEAT_W)
  ) u_supervisor (
    .clk156    (clk156),
    .eth_rst   (eth_rst),
    .a0_d_i    (algn0_d),
    .a0_c_i    (algn0_c),
    .a1_d_i    (algn1_d),
    .a1_c_i    (algn1_c),
    .tx0_d_o   (tx0_d_o),
    .tx0_c_o   (tx0_c_o),
    .tx1_d_o   (tx1_d_o),
    .tx1_c_o   (tx1_c_o),
    .link_up_o (link_up_o),
    .debug_o   (debug_o)
  );

endmodule

// ==== hdl/link_supervisor.sv ====
`timescale 1ns/1ps

module link_supervisor #(
  parameter int GEN_LATENCY = 1024,
  parameter int HEARTBEAT_W = 32
) (
  input  logic                                      clk156,
  input  logic                                      eth_rst,
  input  eth_repeater_pkg::xgmii_data_u             a0_d_i,
  input  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] a0_c_i,
  input  eth_repeater_pkg::xgmii_data_u             a1_d_i,
  input  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] a1_c_i,
  output eth_repeater_pkg::xgmii_data_u             tx0_d_o,
  output logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] tx0_c_o,
  output eth_repeater_pkg::xgmii_data_u             tx1_d_o,
  output logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] tx1_c_o,
  output logic                                      link_up_o,
  output logic [eth_repeater_pkg::DEBUG_W-1:0]      debug_o
);

  // wide enough for GEN_LATENCY-1, even when GEN_LATENCY is 1
  localparam int CNT_W = $clog2(GEN_LATENCY + 1);

  // edges since reset release
  logic [CNT_W-1:0] hold_cnt;

  // free running heartbeat
  logic [HEARTBEAT_W-1:0] hb_cnt;

  // startup hold, link_up set on the GEN_LATENCY-th edge
  always_ff @(posedge clk156) begin
    if (eth_rst) begin
      hold_cnt  <= '0;
      link_up_o <= 1'b0;
    end else if (!link_up_o) begin
      hold_cnt <= hold_cnt + 1'b1;
      if (hold_cnt == CNT_W'(GEN_LATENCY - 1)) begin
        link_up_o <= 1'b1;
      end
    end
  end

  // cross-connect, port 1 rx feeds tx0 and port 0 rx feeds tx1
  // idle until link_up was already high on the previous cycle
  always_ff @(posedge clk156) begin
    if (eth_rst || !link_up_o) begin
      tx0_d_o <= eth_repeater_pkg::IDLE_DATA;
      tx0_c_o <= '1;
      tx1_d_o <= eth_repeater_pkg::IDLE_DATA;
      tx1_c_o <= '1;
    end else begin
      tx0_d_o <= a1_d_i;
      tx0_c_o <= a1_c_i;
      tx1_d_o <= a0_d_i;
      tx1_c_o <= a0_c_i;
    end
  end

  // heartbeat for the leds
  always_ff @(posedge clk156) begin
    if (eth_rst) begin
      hb_cnt <= '0;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
    end
  end

  // top bits only, visible blink rate
  assign debug_o = hb_cnt[HEARTBEAT_W-1 -: eth_repeater_pkg::DEBUG_W];

endmodule

// ==== hdl/xgmii_lane_align.sv ====
`timescale 1ns/1ps

module xgmii_lane_align (
  input  logic                                      clk156,
  input  logic                                      eth_rst,
  input  eth_repeater_pkg::xgmii_data_u             rx_d_i,
  input  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] rx_c_i,
  output eth_repeater_pkg::xgmii_data_u             algn_d_o,
  output logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] algn_c_o
);

  // lanes in one 32-bit half
  localparam int HALF_LANES = eth_repeater_pkg::XGMII_LANES / 2;

  // word from the previous cycle
  eth_repeater_pkg::xgmii_data_u             prev_d;
  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] prev_c;

  // alignment mode, high while a lane 4 frame is being shifted down
  logic shift_q;
  logic shift_nxt;

  // start character seen in the previous word
  logic start_l0;
  logic start_l4;

  // recombined word for shifted mode
  eth_repeater_pkg::xgmii_data_u             mix_d;
  logic [eth_repeater_pkg::XGMII_CTRL_W-1:0] mix_c;

  // start = control bit set and byte is /S/
  assign start_l0 = prev_c[0] &&
                    (prev_d.lane[0] == eth_repeater_pkg::START_CHAR);
  assign start_l4 = prev_c[HALF_LANES] &&
                    (prev_d.lane[HALF_LANES] == eth_repeater_pkg::START_CHAR);

  // lane 4 start wins, mode held between starts
  always_comb begin
    if (start_l4) begin
      shift_nxt = 1'b1;
    end else if (start_l0) begin
      shift_nxt = 1'b0;
    end else begin
      shift_nxt = shift_q;
    end
  end

  // upper half of old word drops to lanes 0..3
  // lower half of new word fills lanes 4..7
  always_comb begin
    mix_d.half[0] = prev_d.half[1];
    mix_d.half[1] = rx_d_i.half[0];
    // control bits follow their bytes
    mix_c = {rx_c_i[HALF_LANES-1:0],
             prev_c[eth_repeater_pkg::XGMII_CTRL_W-1:HALF_LANES]};
  end

  // history stage plus output stage, two cycles in to out
  always_ff @(posedge clk156) begin
    if (eth_rst) begin
      prev_d   <= eth_repeater_pkg::IDLE_DATA;
      prev_c   <= '1;
      shift_q  <= 1'b0;
      algn_d_o <= eth_repeater_pkg::IDLE_DATA;
      algn_c_o <= '1;
    end else begin
      prev_d  <= rx_d_i;
      prev_c  <= rx_c_i;
      shift_q <= shift_nxt;
      // new mode already applies to this word
      if (shift_nxt) begin
        algn_d_o <= mix_d;
        algn_c_o <= mix_c;
      end else begin
        algn_d_o <= prev_d;
        algn_c_o <= prev_c;
      end
    end
  end

endmodule

// ==== hdl/eth_repeater_pkg.sv ====
package eth_repeater_pkg;

  // xgmii word geometry, one control bit per byte lane
  parameter int XGMII_DATA_W = 64;
  parameter int XGMII_CTRL_W = 8;
  parameter int XGMII_LANES  = 8;

  // xgmii control characters
  parameter logic [7:0] IDLE_CHAR  = 8'h07;
  parameter logic [7:0] START_CHAR = 8'hfb;

  // idle in all eight lanes
  // always sent with every control bit set
  parameter logic [XGMII_DATA_W-1:0] IDLE_DATA = {XGMII_LANES{IDLE_CHAR}};

  // board debug leds
  parameter int DEBUG_W = 8;

  // one 64-bit xgmii data word, seen two ways
  // lane[i] is byte lane i, lane 0 in the low bits
  // half[0] holds lanes 0..3, half[1] holds lanes 4..7
  typedef union packed {
    // byte view, start character search
    logic [XGMII_LANES-1:0][7:0]      lane;
    // 32-bit view, lane 4 to lane 0 realignment
    logic [1:0][XGMII_DATA_W/2-1:0]   half;
  } xgmii_data_u;

endpackage
